/* source/stream_macros.svh */
// Stream merge parameters
`ifndef STREAM_MACROS_SVH
`define STREAM_MACROS_SVH

// sample word width in bits
`define DATA_WIDTH   32

// words per channel FIFO, power of two
`define FIFO_DEPTH   16

// number of input streams
`define CHANNELS     2

// buffer words owned by each channel
`define REGION_WORDS 64

// early-full slack in words
`define FULL_MARGIN  3

`endif

/* source/fifoPkg.sv */
// FIFO data and pointer types
`default_nettype none

`include "stream_macros.svh"

package fifoPkg;

    // one sample word, same in FIFO and buffer
    typedef logic [`DATA_WIDTH-1:0] dataWord;

    // FIFO address, wraps on depth
    // no extra lap bit, the early-full margin keeps wp off rp
    typedef logic [$clog2(`FIFO_DEPTH)-1:0] fifoPtr;

endpackage

`default_nettype wire

/* source/busPkg.sv */
// Shared buffer bus types
`default_nettype none

`include "stream_macros.svh"

package busPkg;

    // buffer word address, all regions together
    typedef logic [$clog2(`CHANNELS * `REGION_WORDS)-1:0] memAddr;

    // requester number
    // 0 and 1 are the drains, 2 is readback
    typedef logic [1:0] reqIdx;

    // access kind carried with req
    typedef enum logic
    {
        CMD_WRITE = 1'b0,
        CMD_READ  = 1'b1
    } memCmd;

endpackage

`default_nettype wire

/* source/memBusIf.sv */
// Buffer memory requester bus
`timescale 1ns/1ps
`default_nettype none

interface memBusIf;

    // request side, held steady until gnt
    logic              req;
    busPkg::memCmd     cmd;
    busPkg::memAddr    addr;
    fifoPkg::dataWord  wdata;

    // arbiter side
    // gnt is a one cycle pulse, rvalid follows it for reads
    logic              gnt;
    fifoPkg::dataWord  rdata;
    logic              rvalid;

    modport requester
    (
        output req,
        output cmd,
        output addr,
        output wdata,
        input  gnt,
        input  rdata,
        input  rvalid
    );

    modport arbiter
    (
        input  req,
        input  cmd,
        input  addr,
        input  wdata,
        output gnt,
        output rdata,
        output rvalid
    );

endinterface

`default_nettype wire

/* source/userFifoDual.sv */
// Dual clock FIFO storage
`timescale 1ns/1ps
`default_nettype none

module userFifoDual
(
    input  wire logic              iCLKA,
    input  wire logic              iCLKB,
    input  wire logic              iWE,
    input  wire fifoPkg::fifoPtr   iWA,
    input  wire fifoPkg::dataWord  iWD,
    input  wire fifoPkg::fifoPtr   iRA,
    output fifoPkg::dataWord       oRD
);

    // simple dual port array, one word per pointer value
    fifoPkg::dataWord ram [0:(1 << $bits(fifoPkg::fifoPtr))-1];

    // write port, producer clock
    always_ff @(posedge iCLKA)
    begin
        if (iWE)
        begin
            ram[iWA] <= iWD;
        end
    end

    // read port, registered on the consumer clock
    // no enable, follows iRA every cycle
    always_ff @(posedge iCLKB)
    begin
        oRD <= ram[iRA];
    end

endmodule

`default_nettype wire

/* source/fifoDualControllerGray.sv */
// Dual clock FIFO pointer control
`timescale 1ns/1ps
`default_nettype none

`include "stream_macros.svh"

module fifoDualControllerGray
(
    input  wire logic              iCLKA,
    input  wire logic              iCLKB,
    input  wire logic              iRST,
    input  wire fifoPkg::dataWord  iWD,
    input  wire logic              iWE,
    output logic                   oFLL,
    output fifoPkg::dataWord       oRD,
    input  wire logic              iRE,
    output logic                   oRVD,
    output logic                   oEMP
);

    localparam int AW = $bits(fifoPkg::fifoPtr);

    // binary to gray, one bit changes per increment
    function automatic fifoPkg::fifoPtr binToGray(input fifoPkg::fifoPtr bin);
        return bin ^ (bin >> 1);
    endfunction

    // gray back to binary, msb down
    function automatic fifoPkg::fifoPtr grayToBin(input fifoPkg::fifoPtr gray);
        fifoPkg::fifoPtr bin;
        bin[AW-1] = gray[AW-1];
        for (int i = AW - 2; i >= 0; i--)
        begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // write domain
    fifoPkg::fifoPtr wrPtr;
    fifoPkg::fifoPtr wrGray;
    fifoPkg::fifoPtr rdGraySync1;
    fifoPkg::fifoPtr rdGraySync2;
    fifoPkg::fifoPtr rdBinSync;
    logic            nearFull;

    // read domain
    fifoPkg::fifoPtr rdPtr;
    fifoPkg::fifoPtr rdPtrPrev;
    fifoPkg::fifoPtr rdGray;
    fifoPkg::fifoPtr wrGraySync1;
    fifoPkg::fifoPtr wrGraySync2;
    fifoPkg::fifoPtr wrBinSync;
    logic            rdAccept;

    // -------------------------------------------------------------------------
    // write side, iCLKA
    // -------------------------------------------------------------------------

    // iWE is not gated by full, overrun is the producer's fault
    always_ff @(posedge iCLKA)
    begin
        if (iRST)
        begin
            wrPtr  <= '0;
            wrGray <= '0;
        end
        else
        begin
            if (iWE)
            begin
                wrPtr <= wrPtr + 1'b1;
            end
            // gray lags the binary pointer by one edge
            // so the word is in the array before the pointer crosses
            wrGray <= binToGray(wrPtr);
        end
    end

    // read pointer into the write clock, two flops
    always_ff @(posedge iCLKA)
    begin
        if (iRST)
        begin
            rdGraySync1 <= '0;
            rdGraySync2 <= '0;
            oFLL        <= 1'b0;
        end
        else
        begin
            rdGraySync1 <= rdGray;
            rdGraySync2 <= rdGraySync1;
            oFLL        <= nearFull;
        end
    end

    assign rdBinSync = grayToBin(rdGraySync2);

    // early full, wp within the margin behind the synced rp
    // synced rp is stale, so this only errs on the safe side
    always_comb
    begin
        nearFull = 1'b0;
        for (int k = 1; k <= `FULL_MARGIN; k++)
        begin
            if (fifoPkg::fifoPtr'(wrPtr + k) == rdBinSync)
            begin
                nearFull = 1'b1;
            end
        end
    end

    // -------------------------------------------------------------------------
    // read side, iCLKB
    // -------------------------------------------------------------------------

    assign wrBinSync = grayToBin(wrGraySync2);

    // empty straight from registers, fresh the cycle after a pop
    assign oEMP     = (wrBinSync == rdPtr);
    assign rdAccept = iRE & ~oEMP;

    always_ff @(posedge iCLKB)
    begin
        if (iRST)
        begin
            rdPtr       <= '0;
            rdPtrPrev   <= '0;
            rdGray      <= '0;
            wrGraySync1 <= '0;
            wrGraySync2 <= '0;
            oRVD        <= 1'b0;
        end
        else
        begin
            if (rdAccept)
            begin
                rdPtr <= rdPtr + 1'b1;
            end
            rdPtrPrev   <= rdPtr;
            rdGray      <= binToGray(rdPtr);
            wrGraySync1 <= wrGray;
            wrGraySync2 <= wrGraySync1;
            // pointer moved last cycle, word arrives with this strobe
            oRVD        <= (rdPtr != rdPtrPrev);
        end
    end

    // array read on the previous pointer
    // lines oRD up with oRVD, two cycles after iRE
    userFifoDual fifoRam
    (
        .iCLKA (iCLKA),
        .iCLKB (iCLKB),
        .iWE   (iWE),
        .iWA   (wrPtr),
        .iWD   (iWD),
        .iRA   (rdPtrPrev),
        .oRD   (oRD)
    );

endmodule

`default_nettype wire

/* source/channelDrain.sv */
// Channel drain engine
`timescale 1ns/1ps
`default_nettype none

`include "stream_macros.svh"

module channelDrain #(
    // first buffer word of this channel's region
    parameter busPkg::memAddr pRegionBase = '0
)
(
    input  wire logic              iCLKB,
    input  wire logic              iRST,
    input  wire logic              iDrainEn,
    input  wire logic              iEmpty,
    input  wire logic              iRVD,
    input  wire fifoPkg::dataWord  iRD,
    output logic                   oRE,
    memBusIf.requester             bus,
    output busPkg::memAddr         oWordCount
);

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_WAIT_DATA,
        ST_WAIT_GNT
    } drainState;

    drainState        state;
    busPkg::memAddr   count;
    fifoPkg::dataWord wordQ;
    logic             regionFull;

    // region exhausted, stop popping
    assign regionFull = (count == busPkg::memAddr'(`REGION_WORDS));

    // one pop at a time, only from idle
    assign oRE = (state == ST_IDLE) && iDrainEn && !iEmpty && !regionFull;

    // sequencer
    always_ff @(posedge iCLKB)
    begin
        if (iRST)
        begin
            state <= ST_IDLE;
            count <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (oRE)
                    begin
                        state <= ST_WAIT_DATA;
                    end
                end
                ST_WAIT_DATA:
                begin
                    // word shows up two cycles after the pop
                    if (iRVD)
                    begin
                        state <= ST_WAIT_GNT;
                    end
                end
                ST_WAIT_GNT:
                begin
                    // write lands on the grant edge
                    if (bus.gnt)
                    begin
                        state <= ST_IDLE;
                        count <= count + 1'b1;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // held word, payload only
    always_ff @(posedge iCLKB)
    begin
        if (state == ST_WAIT_DATA && iRVD)
        begin
            wordQ <= iRD;
        end
    end

    // request fields stay put until gnt since count moves only then
    assign bus.req    = (state == ST_WAIT_GNT);
    assign bus.cmd    = busPkg::CMD_WRITE;
    assign bus.addr   = pRegionBase + count;
    assign bus.wdata  = wordQ;
    assign oWordCount = count;

endmodule

`default_nettype wire

/* source/memArbiter.sv */
// Round-robin buffer memory arbiter
`timescale 1ns/1ps
`default_nettype none

`include "stream_macros.svh"

module memArbiter
(
    input  wire logic  iCLKB,
    input  wire logic  iRST,
    memBusIf.arbiter   drain0,
    memBusIf.arbiter   drain1,
    memBusIf.arbiter   rb
);

    // drains plus the readback port
    localparam int PEERS = `CHANNELS + 1;

    logic [PEERS-1:0]  reqVec;
    logic [PEERS-1:0]  readVec;
    busPkg::memCmd     cmdVec   [PEERS];
    busPkg::memAddr    addrVec  [PEERS];
    fifoPkg::dataWord  wdataVec [PEERS];

    logic [PEERS-1:0]  gntQ;
    logic [PEERS-1:0]  rvalidQ;
    busPkg::reqIdx     lastIdx;
    busPkg::reqIdx     pick;
    logic              found;

    // single port buffer, one region per channel
    fifoPkg::dataWord  mem [0:`CHANNELS*`REGION_WORDS-1];
    fifoPkg::dataWord  memQ;
    fifoPkg::dataWord  rdataQ;

    // -------------------------------------------------------------------------
    // gather peers, index order 0 1 2
    // -------------------------------------------------------------------------

    assign reqVec      = {rb.req, drain1.req, drain0.req};
    assign cmdVec[0]   = drain0.cmd;
    assign cmdVec[1]   = drain1.cmd;
    assign cmdVec[2]   = rb.cmd;
    assign addrVec[0]  = drain0.addr;
    assign addrVec[1]  = drain1.addr;
    assign addrVec[2]  = rb.addr;
    assign wdataVec[0] = drain0.wdata;
    assign wdataVec[1] = drain1.wdata;
    assign wdataVec[2] = rb.wdata;

    always_comb
    begin
        for (int k = 0; k < PEERS; k++)
        begin
            readVec[k] = (cmdVec[k] == busPkg::CMD_READ);
        end
    end

    // rotate from the peer after the last grantee
    // a peer in its gnt cycle still holds req, so it is skipped
    always_comb
    begin
        int cand;
        pick  = lastIdx;
        found = 1'b0;
        for (int k = 1; k <= PEERS; k++)
        begin
            cand = (int'(lastIdx) + k) % PEERS;
            if (!found && reqVec[cand] && !gntQ[cand])
            begin
                found = 1'b1;
                pick  = busPkg::reqIdx'(cand);
            end
        end
    end

    // -------------------------------------------------------------------------
    // grant and access
    // -------------------------------------------------------------------------

    always_ff @(posedge iCLKB)
    begin
        if (iRST)
        begin
            gntQ    <= '0;
            rvalidQ <= '0;
            lastIdx <= busPkg::reqIdx'(PEERS - 1);
        end
        else
        begin
            gntQ <= '0;
            if (found)
            begin
                gntQ[pick] <= 1'b1;
                lastIdx    <= pick;
            end
            // read data goes out one cycle behind gnt
            rvalidQ <= gntQ & readVec;
        end
    end

    // the one access per cycle happens on the grant edge
    always_ff @(posedge iCLKB)
    begin
        if (found)
        begin
            if (readVec[pick])
            begin
                memQ <= mem[addrVec[pick]];
            end
            else
            begin
                mem[addrVec[pick]] <= wdataVec[pick];
            end
        end
        rdataQ <= memQ;
    end

    assign drain0.gnt    = gntQ[0];
    assign drain1.gnt    = gntQ[1];
    assign rb.gnt        = gntQ[2];
    assign drain0.rvalid = rvalidQ[0];
    assign drain1.rvalid = rvalidQ[1];
    assign rb.rvalid     = rvalidQ[2];
    assign drain0.rdata  = rdataQ;
    assign drain1.rdata  = rdataQ;
    assign rb.rdata      = rdataQ;

endmodule

`default_nettype wire

/* source/streamMerge.sv */
// Two stream merge into shared buffer
`timescale 1ns/1ps
`default_nettype none

`include "stream_macros.svh"

module streamMerge
(
    input  wire logic              iCLKA,
    input  wire logic              iCLKB,
    input  wire logic              iRST,
    input  wire fifoPkg::dataWord  iWrData0,
    input  wire logic              iWrEn0,
    output logic                   oFull0,
    input  wire fifoPkg::dataWord  iWrData1,
    input  wire logic              iWrEn1,
    output logic                   oFull1,
    input  wire logic [1:0]        iDrainEn,
    output logic [1:0]             oEmpty,
    output busPkg::memAddr         oCount0,
    output busPkg::memAddr         oCount1,
    input  wire logic              iRbStart,
    input  wire busPkg::memAddr    iRbAddr,
    output fifoPkg::dataWord       oRbData,
    output logic                   oRbValid
);

    // FIFO to drain strobes, per channel
    fifoPkg::dataWord fifoRd [2];
    logic [1:0]       fifoRvd;
    logic [1:0]       fifoRe;

    // readback holding register
    logic             rbReq;
    busPkg::memAddr   rbAddr;

    memBusIf busDrain0 ();
    memBusIf busDrain1 ();
    memBusIf busRb ();

    // -------------------------------------------------------------------------
    // channel 0
    // -------------------------------------------------------------------------

    fifoDualControllerGray fifoCh0
    (
        .iCLKA (iCLKA),
        .iCLKB (iCLKB),
        .iRST  (iRST),
        .iWD   (iWrData0),
        .iWE   (iWrEn0),
        .oFLL  (oFull0),
        .oRD   (fifoRd[0]),
        .iRE   (fifoRe[0]),
        .oRVD  (fifoRvd[0]),
        .oEMP  (oEmpty[0])
    );

    channelDrain #(
        .pRegionBase (busPkg::memAddr'(0))
    ) drainCh0 (
        .iCLKB      (iCLKB),
        .iRST       (iRST),
        .iDrainEn   (iDrainEn[0]),
        .iEmpty     (oEmpty[0]),
        .iRVD       (fifoRvd[0]),
        .iRD        (fifoRd[0]),
        .oRE        (fifoRe[0]),
        .bus        (busDrain0.requester),
        .oWordCount (oCount0)
    );

    // -------------------------------------------------------------------------
    // channel 1, region starts one region up
    // -------------------------------------------------------------------------

    fifoDualControllerGray fifoCh1
    (
        .iCLKA (iCLKA),
        .iCLKB (iCLKB),
        .iRST  (iRST),
        .iWD   (iWrData1),
        .iWE   (iWrEn1),
        .oFLL  (oFull1),
        .oRD   (fifoRd[1]),
        .iRE   (fifoRe[1]),
        .oRVD  (fifoRvd[1]),
        .oEMP  (oEmpty[1])
    );

    channelDrain #(
        .pRegionBase (busPkg::memAddr'(`REGION_WORDS))
    ) drainCh1 (
        .iCLKB      (iCLKB),
        .iRST       (iRST),
        .iDrainEn   (iDrainEn[1]),
        .iEmpty     (oEmpty[1]),
        .iRVD       (fifoRvd[1]),
        .iRD        (fifoRd[1]),
        .oRE        (fifoRe[1]),
        .bus        (busDrain1.requester),
        .oWordCount (oCount1)
    );

    // -------------------------------------------------------------------------
    // readback port, third peer on the arbiter
    // -------------------------------------------------------------------------

    // start loads the address and raises req, gnt drops it
    always_ff @(posedge iCLKB)
    begin
        if (iRST)
        begin
            rbReq <= 1'b0;
        end
        else if (iRbStart)
        begin
            rbReq <= 1'b1;
        end
        else if (busRb.gnt)
        begin
            rbReq <= 1'b0;
        end
    end

    always_ff @(posedge iCLKB)
    begin
        if (iRbStart)
        begin
            rbAddr <= iRbAddr;
        end
    end

    assign busRb.req   = rbReq;
    assign busRb.cmd   = busPkg::CMD_READ;
    assign busRb.addr  = rbAddr;
    assign busRb.wdata = '0;
    assign oRbData     = busRb.rdata;
    assign oRbValid    = busRb.rvalid;

    memArbiter arbiter
    (
        .iCLKB  (iCLKB),
        .iRST   (iRST),
        .drain0 (busDrain0.arbiter),
        .drain1 (busDrain1.arbiter),
        .rb     (busRb.arbiter)
    );

endmodule

`default_nettype wire

/* verification/tbStreamMerge.sv */
// Stream merge testbench
`timescale 1ns/1ps
`default_nettype none

`include "stream_macros.svh"

module tbStreamMerge;

    localparam int PERIOD_B    = 20;
    localparam int TOTAL_WORDS = 20 + 2 * 30 + `FIFO_DEPTH + 2 * 12;
    localparam int WATCHDOG_NS = (200 * TOTAL_WORDS + 2000) * PERIOD_B;

    logic             iCLKA;
    logic             iCLKB;
    logic             iRST;
    fifoPkg::dataWord iWrData0;
    logic             iWrEn0;
    logic             oFull0;
    fifoPkg::dataWord iWrData1;
    logic             iWrEn1;
    logic             oFull1;
    logic [1:0]       iDrainEn;
    logic [1:0]       oEmpty;
    busPkg::memAddr   oCount0;
    busPkg::memAddr   oCount1;
    logic             iRbStart;
    busPkg::memAddr   iRbAddr;
    fifoPkg::dataWord oRbData;
    logic             oRbValid;

    // model queues of accepted words per channel in write order
    fifoPkg::dataWord q0 [$];
    fifoPkg::dataWord q1 [$];

    int seed = 65;
    int errCount = 0;
    int errMark = 0;
    int passed = 0;
    int failed = 0;
    int accepted;
    int firstIdx;

    streamMerge i_streamMerge
    (
        .iCLKA    (iCLKA),
        .iCLKB    (iCLKB),
        .iRST     (iRST),
        .iWrData0 (iWrData0),
        .iWrEn0   (iWrEn0),
        .oFull0   (oFull0),
        .iWrData1 (iWrData1),
        .iWrEn1   (iWrEn1),
        .oFull1   (oFull1),
        .iDrainEn (iDrainEn),
        .oEmpty   (oEmpty),
        .oCount0  (oCount0),
        .oCount1  (oCount1),
        .iRbStart (iRbStart),
        .iRbAddr  (iRbAddr),
        .oRbData  (oRbData),
        .oRbValid (oRbValid)
    );

    // consumer clock 20 ns
    initial
    begin
        iCLKB = 1'b0;
        forever #(PERIOD_B / 2) iCLKB = ~iCLKB;
    end

    // producer clock 26 ns
    initial
    begin
        iCLKA = 1'b0;
        forever #13 iCLKA = ~iCLKA;
    end

    // watchdog sized from the total word count
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    // -------------------------------------------------------------------------
    // helpers
    // -------------------------------------------------------------------------

    function automatic int countOf(input int ch);
        return (ch == 0) ? int'(oCount0) : int'(oCount1);
    endfunction

    function automatic logic fullOf(input int ch);
        return (ch == 0) ? oFull0 : oFull1;
    endfunction

    // one write cycle on a channel
    // data only matters with en
    task automatic driveWrite(input int ch, input logic en, input fifoPkg::dataWord w);
        if (ch == 0)
        begin
            iWrEn0   = en;
            iWrData0 = w;
        end
        else
        begin
            iWrEn1   = en;
            iWrData1 = w;
        end
    endtask

    // n words into a channel while full is low
    task automatic writeStream(input int ch, input int n, input bit gaps);
        int sent;
        int r;
        fifoPkg::dataWord w;
        sent = 0;
        while (sent < n)
        begin
            @(posedge iCLKA);
            #2;
            r = $random(seed);
            w = $random(seed);
            driveWrite(ch, 1'b0, '0);
            if (!fullOf(ch) && (!gaps || (r & 3) != 0))
            begin
                driveWrite(ch, 1'b1, w);
                if (ch == 0)
                    q0.push_back(w);
                else
                    q1.push_back(w);
                sent++;
            end
        end
        @(posedge iCLKA);
        #2;
        driveWrite(ch, 1'b0, '0);
    endtask

    // wait for the drain to store target words
    task automatic waitCount(input int ch, input int target);
        int cycles;
        cycles = 0;
        while (countOf(ch) < target && cycles < 200 * target + 500)
        begin
            @(posedge iCLKB);
            #2;
            cycles++;
        end
        if (countOf(ch) < target)
        begin
            $display("channel %0d stored only %0d of %0d words in time", ch, countOf(ch), target);
            errCount++;
        end
        else if (countOf(ch) != target)
        begin
            $display("** Error @ %0t: channel %0d count %0d, expected %0d",
                     $time, ch, countOf(ch), target);
            errCount++;
        end
    endtask

    // wait for both FIFOs to report empty
    task automatic waitEmpty(input int limit);
        int cycles;
        cycles = 0;
        while (oEmpty !== 2'b11 && cycles < limit)
        begin
            @(posedge iCLKB);
            #2;
            cycles++;
        end
        if (oEmpty !== 2'b11)
        begin
            $display("** Error @ %0t: oEmpty %b after drain, expected 11", $time, oEmpty);
            errCount++;
        end
    endtask

    // read word idx of a channel region and compare with the queue
    task automatic readCheck(input int ch, input int idx);
        fifoPkg::dataWord exp;
        int cycles;
        exp = (ch == 0) ? q0[idx] : q1[idx];
        @(posedge iCLKB);
        #2;
        iRbStart = 1'b1;
        iRbAddr  = busPkg::memAddr'(ch * `REGION_WORDS + idx);
        @(posedge iCLKB);
        #2;
        iRbStart = 1'b0;
        cycles   = 0;
        while (!oRbValid && cycles < 20)
        begin
            @(posedge iCLKB);
            #2;
            cycles++;
        end
        if (!oRbValid)
        begin
            $display("readback of channel %0d word %0d never completed", ch, idx);
            errCount++;
        end
        else if (oRbData !== exp)
        begin
            $display("** Error @ %0t: channel %0d word %0d read %h, expected %h",
                     $time, ch, idx, oRbData, exp);
            errCount++;
        end
    endtask

    task automatic regionCheck(input int ch, input int first, input int last);
        for (int i = first; i <= last; i++)
        begin
            readCheck(ch, i);
        end
    endtask

    // random readbacks of words already stored
    task automatic readDuringDrain(input int reads);
        int ch;
        int n;
        int r;
        repeat (reads)
        begin
            r  = $random(seed);
            ch = r & 1;
            n  = countOf(ch);
            r  = $random(seed);
            readCheck(ch, (r & 32'h7fff_ffff) % n);
        end
    endtask

    task automatic finishTest(input string name);
        if (errCount == errMark)
        begin
            passed++;
            $display("test %s: passed", name);
        end
        else
        begin
            failed++;
            $display("test %s: failed with %0d errors", name, errCount - errMark);
        end
        errMark = errCount;
    endtask

    // -------------------------------------------------------------------------
    // test sequence
    // -------------------------------------------------------------------------

    initial
    begin
        iRST     = 1'b1;
        iWrData0 = '0;
        iWrEn0   = 1'b0;
        iWrData1 = '0;
        iWrEn1   = 1'b0;
        iDrainEn = 2'b00;
        iRbStart = 1'b0;
        iRbAddr  = '0;
        repeat (5) @(posedge iCLKB);
        #2;
        iRST = 1'b0;
        @(posedge iCLKB);
        #2;

        // reset state
        if (oEmpty !== 2'b11 || oFull0 !== 1'b0 || oFull1 !== 1'b0)
        begin
            $display("** Error @ %0t: flags after reset empty %b full %b%b",
                     $time, oEmpty, oFull1, oFull0);
            errCount++;
        end
        if (oCount0 !== '0 || oCount1 !== '0)
        begin
            $display("** Error @ %0t: counts after reset %0d %0d", $time, oCount0, oCount1);
            errCount++;
        end
        if (oRbValid !== 1'b0)
        begin
            $display("** Error @ %0t: oRbValid %b after reset, expected 0", $time, oRbValid);
            errCount++;
        end
        finishTest("reset state");

        // channel 0 alone with random gaps
        iDrainEn = 2'b11;
        writeStream(0, 20, 1'b1);
        waitCount(0, q0.size());
        regionCheck(0, 0, 19);
        finishTest("single channel order");

        // both channels race for the arbiter
        fork
            writeStream(0, 30, 1'b0);
            writeStream(1, 30, 1'b0);
        join
        waitCount(0, q0.size());
        waitCount(1, q1.size());
        regionCheck(0, 20, q0.size() - 1);
        regionCheck(1, 0, q1.size() - 1);
        finishTest("concurrent channels");

        // channel 1 drain stalled until full rises
        @(posedge iCLKB);
        #2;
        iDrainEn = 2'b01;
        firstIdx = q1.size();
        accepted = 0;
        repeat (2 * `FIFO_DEPTH)
        begin
            @(posedge iCLKA);
            #2;
            iWrEn1 = 1'b0;
            if (!oFull1)
            begin
                iWrData1 = $random(seed);
                iWrEn1   = 1'b1;
                q1.push_back(iWrData1);
                accepted++;
            end
        end
        @(posedge iCLKA);
        #2;
        iWrEn1 = 1'b0;
        if (!oFull1)
        begin
            $display("** Error @ %0t: oFull1 %b with the drain stopped, expected 1",
                     $time, oFull1);
            errCount++;
        end
        if (accepted < `FIFO_DEPTH - `FULL_MARGIN - 3 || accepted > `FIFO_DEPTH - 1)
        begin
            $display("** Error @ %0t: %0d words accepted before full", $time, accepted);
            errCount++;
        end
        @(posedge iCLKB);
        #2;
        iDrainEn = 2'b11;
        waitCount(1, q1.size());
        regionCheck(1, firstIdx, q1.size() - 1);
        waitEmpty(20);
        finishTest("back-pressure");

        // readbacks while both drains still write
        fork
            writeStream(0, 12, 1'b1);
            writeStream(1, 12, 1'b1);
            readDuringDrain(16);
        join
        waitCount(0, q0.size());
        waitCount(1, q1.size());
        finishTest("readback during drain");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 passed + failed, passed, failed, errCount);
        if (errCount == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/fifoPkg.sv
source/busPkg.sv
source/memBusIf.sv
source/userFifoDual.sv
source/fifoDualControllerGray.sv
source/channelDrain.sv
source/memArbiter.sv
source/streamMerge.sv
verification/tbStreamMerge.sv

/* Makefile */
# Verilator build and run for the stream merge testbench

TOP := tbStreamMerge
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "^RESULT: PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
